/* build.f */
source/sentinel_pkg.sv
source/profiler_regs_pkg.sv
source/sentinel_decode.sv
source/latency_track.sv
source/latency_accum.sv
source/profiler_apb_regs.sv
source/sentinel_profiler.sv
test/sentinel_profiler_properties.sv
test/sentinel_profiler_tb.sv

/* run.sh */
#!/bin/sh
# Compile the profiler testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module sentinel_profiler_tb -f build.f -Mdir obj_dir -o sim

# A failing assertion may stop the simulator, the log decides the result
./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "All checks passed" sim.log; then
  exit 0
fi
exit 1

/* source/latency_accum.sv */
// Stage 3 of the profiler
// Last TOTAL latency, saturating CMI/CMO/CMP accumulators and unmatched counts,
// plus the cross-tile maxima one cycle behind

`default_nettype none

module latency_accum
  import sentinel_pkg::*;
  import profiler_regs_pkg::*;
(
  input  logic                clk,
  input  logic                i_arst_n,
  input  logic                i_clear,
  input  logic [N_TILES-1:0]  i_lat_valid,
  input  category_e           i_lat_cat [N_TILES],
  input  cycle_t              i_lat_value [N_TILES],
  input  logic [N_TILES-1:0]  i_unmatched,
  output acc_t                o_last_total [N_TILES],
  output acc_t                o_acc_cmi [N_TILES],
  output acc_t                o_acc_cmo [N_TILES],
  output acc_t                o_acc_cmp [N_TILES],
  output err_cnt_t            o_unmatched_cnt [N_TILES],
  output acc_t                o_max_cmi,
  output acc_t                o_max_cmo,
  output acc_t                o_max_cmp,
  output acc_t                o_max_sum
);

  acc_t     acc_q [N_TILES][N_CAT];  // TOTAL entry keeps the last latency only
  err_cnt_t err_q [N_TILES];
  acc_t     sum_tile [N_TILES];
  acc_t     max_d [N_CAT];           // TOTAL entry holds the max of CMI+CMO+CMP
  acc_t     max_q [N_CAT];

  function automatic acc_t sat_add(acc_t a, acc_t b);
    logic [ACC_W:0] s;
    s = {1'b0, a} + {1'b0, b};
    return s[ACC_W] ? '1 : s[ACC_W-1:0];
  endfunction

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      acc_q <= '{default: '0};
      err_q <= '{default: '0};
    end else if (i_clear) begin
      acc_q <= '{default: '0};
      err_q <= '{default: '0};
    end else begin
      for (int t = 0; t < N_TILES; t++) begin
        if (i_lat_valid[t]) begin
          if (i_lat_cat[t] == CAT_TOTAL) begin
            acc_q[t][CAT_TOTAL] <= i_lat_value[t];
          end else begin
            acc_q[t][i_lat_cat[t]] <= sat_add(acc_q[t][i_lat_cat[t]], i_lat_value[t]);
          end
        end
        if (i_unmatched[t] && (err_q[t] != '1)) begin
          err_q[t] <= err_q[t] + 1'b1;
        end
      end
    end
  end

  // Largest value over all tiles
  always_comb begin
    max_d = '{default: '0};
    for (int t = 0; t < N_TILES; t++) begin
      sum_tile[t] = sat_add(sat_add(acc_q[t][CAT_CMI], acc_q[t][CAT_CMO]),
                            acc_q[t][CAT_CMP]);
      if (sum_tile[t] > max_d[CAT_TOTAL]) begin
        max_d[CAT_TOTAL] = sum_tile[t];
      end
      for (int c = int'(CAT_CMI); c < N_CAT; c++) begin
        if (acc_q[t][c] > max_d[c]) begin
          max_d[c] = acc_q[t][c];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      max_q <= '{default: '0};
    end else if (i_clear) begin
      max_q <= '{default: '0};
    end else begin
      max_q <= max_d;
    end
  end

  always_comb begin
    for (int t = 0; t < N_TILES; t++) begin
      o_last_total[t]    = acc_q[t][CAT_TOTAL];
      o_acc_cmi[t]       = acc_q[t][CAT_CMI];
      o_acc_cmo[t]       = acc_q[t][CAT_CMO];
      o_acc_cmp[t]       = acc_q[t][CAT_CMP];
      o_unmatched_cnt[t] = err_q[t];
    end
  end

  assign o_max_cmi = max_q[CAT_CMI];
  assign o_max_cmo = max_q[CAT_CMO];
  assign o_max_cmp = max_q[CAT_CMP];
  assign o_max_sum = max_q[CAT_TOTAL];

endmodule

`default_nettype wire

/* source/latency_track.sv */
// Stage 2 of the profiler
// Free-running cycle counter, open start slots per tile and category,
// and the latency or unmatched result of each finish event

`default_nettype none

module latency_track
  import sentinel_pkg::*;
  import profiler_regs_pkg::*;
(
  input  logic                clk,
  input  logic                i_arst_n,
  input  logic                i_clear,
  input  logic [N_TILES-1:0]  i_ev_valid,
  input  logic [N_TILES-1:0]  i_ev_start,
  input  category_e           i_ev_cat [N_TILES],
  output logic [N_TILES-1:0]  o_lat_valid,
  output category_e           o_lat_cat [N_TILES],
  output cycle_t              o_lat_value [N_TILES],
  output logic [N_TILES-1:0]  o_unmatched
);

  cycle_t           cycle_q;
  logic [N_CAT-1:0] open_q  [N_TILES];         // One slot per category, no nesting
  cycle_t           stamp_q [N_TILES][N_CAT];

  // Time base shared by all tiles
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  // Slot flags and result strobes
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_lat_valid <= '0;
      o_unmatched <= '0;
      for (int t = 0; t < N_TILES; t++) begin
        open_q[t] <= '0;
      end
    end else begin
      for (int t = 0; t < N_TILES; t++) begin
        o_lat_valid[t] <= 1'b0;
        o_unmatched[t] <= 1'b0;
        if (i_clear) begin
          open_q[t] <= '0;  // Drops open slots and any event this cycle
        end else if (i_ev_valid[t]) begin
          if (i_ev_start[t]) begin
            open_q[t][i_ev_cat[t]] <= 1'b1;  // A second start just restamps
          end else if (open_q[t][i_ev_cat[t]]) begin
            open_q[t][i_ev_cat[t]] <= 1'b0;
            o_lat_valid[t]         <= 1'b1;
          end else begin
            o_unmatched[t] <= 1'b1;          // Finish with no open start
          end
        end
      end
    end
  end

  // Stamps and latency payload
  always_ff @(posedge clk) begin
    for (int t = 0; t < N_TILES; t++) begin
      if (i_ev_valid[t]) begin
        if (i_ev_start[t]) begin
          stamp_q[t][i_ev_cat[t]] <= cycle_q;
        end
        o_lat_cat[t]   <= i_ev_cat[t];
        o_lat_value[t] <= cycle_q - stamp_q[t][i_ev_cat[t]] -
                          cycle_t'(SENTINEL_OVERHEAD);
      end
    end
  end

endmodule

`default_nettype wire

/* source/profiler_apb_regs.sv */
// APB slave of the profiler, zero wait states
// Read mux over per-tile and global results, error flag, clear command

`default_nettype none

module profiler_apb_regs
  import sentinel_pkg::*;
  import profiler_regs_pkg::*;
(
  input  logic                   clk,
  input  logic                   i_arst_n,
  // APB
  input  logic                   i_psel,
  input  logic                   i_penable,
  input  logic                   i_pwrite,
  input  logic [APB_ADDR_W-1:0]  i_paddr,
  input  logic [APB_DATA_W-1:0]  i_pwdata,
  output logic [APB_DATA_W-1:0]  o_prdata,
  output logic                   o_pready,
  output logic                   o_pslverr,
  // Results from stage 3
  input  acc_t                   i_last_total [N_TILES],
  input  acc_t                   i_acc_cmi [N_TILES],
  input  acc_t                   i_acc_cmo [N_TILES],
  input  acc_t                   i_acc_cmp [N_TILES],
  input  err_cnt_t               i_unmatched_cnt [N_TILES],
  input  acc_t                   i_max_cmi,
  input  acc_t                   i_max_cmo,
  input  acc_t                   i_max_cmp,
  input  acc_t                   i_max_sum,
  output logic                   o_clear
);

  logic                   access;
  logic                   in_tiles;
  logic                   mapped;
  logic                   is_clear;
  logic [TILE_W-1:0]      tile_idx;
  logic [TILE_OFS_W-1:0]  ofs;
  logic [APB_DATA_W-1:0]  rdata;
  logic                   clear_q;

  assign access   = i_psel & i_penable;
  assign tile_idx = i_paddr[TILE_OFS_W +: TILE_W];
  assign ofs      = i_paddr[TILE_OFS_W-1:0];
  assign in_tiles = (i_paddr[APB_ADDR_W-1:TILE_OFS_W+TILE_W] == '0);  // Below 0x80
  assign is_clear = (i_paddr == ADDR_CLEAR);

  always_comb begin
    rdata  = '0;
    mapped = 1'b1;
    if (in_tiles) begin
      case (ofs)
        OFS_TOTAL:     rdata = i_last_total[tile_idx];
        OFS_CMI:       rdata = i_acc_cmi[tile_idx];
        OFS_CMO:       rdata = i_acc_cmo[tile_idx];
        OFS_CMP:       rdata = i_acc_cmp[tile_idx];
        OFS_UNMATCHED: rdata = {{(APB_DATA_W-ERR_W){1'b0}}, i_unmatched_cnt[tile_idx]};
        default:       mapped = 1'b0;
      endcase
    end else begin
      case (i_paddr)
        ADDR_MAX_CMI: rdata = i_max_cmi;
        ADDR_MAX_CMO: rdata = i_max_cmo;
        ADDR_MAX_CMP: rdata = i_max_cmp;
        ADDR_MAX_SUM: rdata = i_max_sum;
        ADDR_CLEAR:   rdata = '0;       // Reads back as zero
        default:      mapped = 1'b0;
      endcase
    end
  end

  assign o_pready  = access;
  assign o_prdata  = (access && !i_pwrite) ? rdata : '0;
  // Unmapped address, or a write to anything but the clear register
  assign o_pslverr = access & (~mapped | (i_pwrite & ~is_clear));

  // Any nonzero write to the clear register fires one pulse
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      clear_q <= 1'b0;
    end else begin
      clear_q <= access & i_pwrite & is_clear & (|i_pwdata);
    end
  end

  assign o_clear = clear_q;

endmodule

`default_nettype wire

/* source/profiler_regs_pkg.sv */
// APB register map of the profiler
// Data widths and counter types

`default_nettype none

package profiler_regs_pkg;

  // Cycle stamps and latencies
  localparam int unsigned CYCLE_W = 32;
  typedef logic [CYCLE_W-1:0] cycle_t;

  // Latency accumulators
  localparam int unsigned ACC_W = 32;
  typedef logic [ACC_W-1:0] acc_t;

  // Unmatched finish counters
  localparam int unsigned ERR_W = 8;
  typedef logic [ERR_W-1:0] err_cnt_t;

  // APB bus
  localparam int unsigned APB_ADDR_W = 8;
  localparam int unsigned APB_DATA_W = 32;

  // Per-tile register block
  localparam int unsigned TILE_STRIDE = 32'h20;
  localparam int unsigned TILE_OFS_W  = $clog2(TILE_STRIDE);  // Offset bits inside a block

  localparam logic [TILE_OFS_W-1:0] OFS_TOTAL     = 5'h00;
  localparam logic [TILE_OFS_W-1:0] OFS_CMI       = 5'h04;
  localparam logic [TILE_OFS_W-1:0] OFS_CMO       = 5'h08;
  localparam logic [TILE_OFS_W-1:0] OFS_CMP       = 5'h0C;
  localparam logic [TILE_OFS_W-1:0] OFS_UNMATCHED = 5'h10;

  // Global registers above the tile blocks
  localparam logic [APB_ADDR_W-1:0] ADDR_MAX_CMI = 8'h80;
  localparam logic [APB_ADDR_W-1:0] ADDR_MAX_CMO = 8'h84;
  localparam logic [APB_ADDR_W-1:0] ADDR_MAX_CMP = 8'h88;
  localparam logic [APB_ADDR_W-1:0] ADDR_MAX_SUM = 8'h8C;
  localparam logic [APB_ADDR_W-1:0] ADDR_CLEAR   = 8'h90;  // Write only

endpackage

`default_nettype wire

/* source/sentinel_decode.sv */
// Stage 1 of the profiler
// Recognizes addi x0, x0, imm sentinels on each write-back port

`default_nettype none

module sentinel_decode
  import sentinel_pkg::*;
(
  input  logic                clk,
  input  logic                i_arst_n,
  input  logic [N_TILES-1:0]  i_wb_valid,
  input  sentinel_instr_u     i_wb_instr [N_TILES],
  output logic [N_TILES-1:0]  o_ev_valid,
  output logic [N_TILES-1:0]  o_ev_start,
  output category_e           o_ev_cat [N_TILES]
);

  logic [N_TILES-1:0] hit;
  logic [N_TILES-1:0] is_start;
  category_e          cat [N_TILES];

  always_comb begin
    for (int t = 0; t < N_TILES; t++) begin
      is_start[t] = 1'b0;
      cat[t]      = CAT_TOTAL;
      // Plain addi to x0 from x0, nothing else qualifies
      hit[t] = i_wb_valid[t] &&
               (i_wb_instr[t].f.opcode == OPC_OP_IMM) &&
               (i_wb_instr[t].f.rd == 5'd0) &&
               (i_wb_instr[t].f.rs1 == 5'd0) &&
               (i_wb_instr[t].f.funct3 == 3'd0);
      case (i_wb_instr[t].f.imm)
        IMM_TOTAL_START: is_start[t] = 1'b1;
        IMM_TOTAL_END:   is_start[t] = 1'b0;
        IMM_CMI_START: begin
          is_start[t] = 1'b1;
          cat[t]      = CAT_CMI;
        end
        IMM_CMI_END:     cat[t] = CAT_CMI;
        IMM_CMO_START: begin
          is_start[t] = 1'b1;
          cat[t]      = CAT_CMO;
        end
        IMM_CMO_END:     cat[t] = CAT_CMO;
        IMM_CMP_START: begin
          is_start[t] = 1'b1;
          cat[t]      = CAT_CMP;
        end
        IMM_CMP_END:     cat[t] = CAT_CMP;
        default:         hit[t] = 1'b0;  // Not in the sentinel table
      endcase
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ev_valid <= '0;
    end else begin
      o_ev_valid <= hit;
    end
  end

  // Event payload, only meaningful with o_ev_valid
  always_ff @(posedge clk) begin
    o_ev_start <= is_start;
    for (int t = 0; t < N_TILES; t++) begin
      o_ev_cat[t] <= cat[t];
    end
  end

endmodule

`default_nettype wire

/* source/sentinel_pkg.sv */
// Tile count and sentinel instruction encodings
// Profiling categories and the decoded instruction word

`default_nettype none

package sentinel_pkg;

  // Array size
  localparam int unsigned N_TILES = 4;
  localparam int unsigned TILE_W  = 2;   // Tile index width

  // RISC-V OP-IMM major opcode, carries addi
  localparam logic [6:0] OPC_OP_IMM = 7'h13;

  // Sentinel immediates of addi x0, x0, imm
  localparam logic [11:0] IMM_TOTAL_START = 12'h5AA;
  localparam logic [11:0] IMM_TOTAL_END   = 12'h5FF;
  localparam logic [11:0] IMM_CMI_START   = 12'h50B;  // Input communication
  localparam logic [11:0] IMM_CMI_END     = 12'h50C;
  localparam logic [11:0] IMM_CMO_START   = 12'h51B;  // Output communication
  localparam logic [11:0] IMM_CMO_END     = 12'h51C;
  localparam logic [11:0] IMM_CMP_START   = 12'h52B;  // Computation
  localparam logic [11:0] IMM_CMP_END     = 12'h52C;

  // Cycles spent by the sentinel pair itself
  localparam int unsigned SENTINEL_OVERHEAD = 1;

  // Profiling categories
  typedef enum logic [1:0] {
    CAT_TOTAL = 2'd0,
    CAT_CMI   = 2'd1,
    CAT_CMO   = 2'd2,
    CAT_CMP   = 2'd3
  } category_e;

  localparam int unsigned N_CAT = 4;

  // I-type field layout
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } itype_t;

  // Write-back word, raw on the ports and split into fields for decoding
  typedef union packed {
    logic [31:0] raw;
    itype_t      f;
  } sentinel_instr_u;

endpackage

`default_nettype wire

/* source/sentinel_profiler.sv */
// Top level of the sentinel profiler
// Decode, latency tracking, accumulation and APB register stages

`default_nettype none

module sentinel_profiler
  import sentinel_pkg::*;
  import profiler_regs_pkg::*;
(
  input  logic                   clk,
  input  logic                   i_arst_n,
  // Write-back streams
  input  logic [N_TILES-1:0]     i_wb_valid,
  input  sentinel_instr_u        i_wb_instr [N_TILES],
  // APB
  input  logic                   i_psel,
  input  logic                   i_penable,
  input  logic                   i_pwrite,
  input  logic [APB_ADDR_W-1:0]  i_paddr,
  input  logic [APB_DATA_W-1:0]  i_pwdata,
  output logic [APB_DATA_W-1:0]  o_prdata,
  output logic                   o_pready,
  output logic                   o_pslverr
);

  logic [N_TILES-1:0] ev_valid;
  logic [N_TILES-1:0] ev_start;
  category_e          ev_cat [N_TILES];
  logic [N_TILES-1:0] lat_valid;
  category_e          lat_cat [N_TILES];
  cycle_t             lat_value [N_TILES];
  logic [N_TILES-1:0] unmatched_pulse;
  acc_t               last_total [N_TILES];
  acc_t               acc_cmi [N_TILES];
  acc_t               acc_cmo [N_TILES];
  acc_t               acc_cmp [N_TILES];
  err_cnt_t           unmatched [N_TILES];
  acc_t               max_cmi;
  acc_t               max_cmo;
  acc_t               max_cmp;
  acc_t               max_sum;
  logic               clear;

  sentinel_decode u_decode (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_wb_valid (i_wb_valid),
    .i_wb_instr (i_wb_instr),
    .o_ev_valid (ev_valid),
    .o_ev_start (ev_start),
    .o_ev_cat   (ev_cat)
  );

  latency_track u_track (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_clear     (clear),
    .i_ev_valid  (ev_valid),
    .i_ev_start  (ev_start),
    .i_ev_cat    (ev_cat),
    .o_lat_valid (lat_valid),
    .o_lat_cat   (lat_cat),
    .o_lat_value (lat_value),
    .o_unmatched (unmatched_pulse)
  );

  latency_accum u_accum (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .i_clear         (clear),
    .i_lat_valid     (lat_valid),
    .i_lat_cat       (lat_cat),
    .i_lat_value     (lat_value),
    .i_unmatched     (unmatched_pulse),
    .o_last_total    (last_total),
    .o_acc_cmi       (acc_cmi),
    .o_acc_cmo       (acc_cmo),
    .o_acc_cmp       (acc_cmp),
    .o_unmatched_cnt (unmatched),
    .o_max_cmi       (max_cmi),
    .o_max_cmo       (max_cmo),
    .o_max_cmp       (max_cmp),
    .o_max_sum       (max_sum)
  );

  profiler_apb_regs u_regs (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .i_psel          (i_psel),
    .i_penable       (i_penable),
    .i_pwrite        (i_pwrite),
    .i_paddr         (i_paddr),
    .i_pwdata        (i_pwdata),
    .o_prdata        (o_prdata),
    .o_pready        (o_pready),
    .o_pslverr       (o_pslverr),
    .i_last_total    (last_total),
    .i_acc_cmi       (acc_cmi),
    .i_acc_cmo       (acc_cmo),
    .i_acc_cmp       (acc_cmp),
    .i_unmatched_cnt (unmatched),
    .i_max_cmi       (max_cmi),
    .i_max_cmo       (max_cmo),
    .i_max_cmp       (max_cmp),
    .i_max_sum       (max_sum),
    .o_clear         (clear)
  );

endmodule

`default_nettype wire

/* test/sentinel_profiler_properties.sv */
// Concurrent assertions on the profiler pipeline
// Bound into the top level of the design

`default_nettype none

module sentinel_profiler_properties
  import sentinel_pkg::*;
  import profiler_regs_pkg::*;
(
  input logic                clk,
  input logic                i_arst_n,
  input logic                i_clear,
  input logic [N_TILES-1:0]  i_wb_valid,
  input logic [N_TILES-1:0]  i_ev_valid,
  input acc_t                i_acc_cmi [N_TILES],
  input acc_t                i_acc_cmo [N_TILES],
  input acc_t                i_acc_cmp [N_TILES]
);

  timeunit 1ns;
  timeprecision 1ps;

  // Clear is a single-cycle strobe
  a_clear_pulse: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_clear |=> !i_clear)
    else $error("clear stayed high for more than one cycle");

  // Stage 1 events only come from valid write-back words
  a_event_needs_valid: assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_ev_valid & ~$past(i_wb_valid)) == '0)
    else $error("stage 1 event for a word with the valid bit low");

  for (genvar t = 0; t < N_TILES; t++) begin : g_tile
    a_cmi_no_drop: assert property (@(posedge clk) disable iff (!i_arst_n)
      !$past(i_clear) |-> i_acc_cmi[t] >= $past(i_acc_cmi[t]))
      else $error("acc_cmi[%0d] decreased without a clear", t);
    a_cmo_no_drop: assert property (@(posedge clk) disable iff (!i_arst_n)
      !$past(i_clear) |-> i_acc_cmo[t] >= $past(i_acc_cmo[t]))
      else $error("acc_cmo[%0d] decreased without a clear", t);
    a_cmp_no_drop: assert property (@(posedge clk) disable iff (!i_arst_n)
      !$past(i_clear) |-> i_acc_cmp[t] >= $past(i_acc_cmp[t]))
      else $error("acc_cmp[%0d] decreased without a clear", t);
  end

endmodule

bind sentinel_profiler sentinel_profiler_properties u_properties (
  .clk        (clk),
  .i_arst_n   (i_arst_n),
  .i_clear    (clear),
  .i_wb_valid (i_wb_valid),
  .i_ev_valid (ev_valid),
  .i_acc_cmi  (acc_cmi),
  .i_acc_cmo  (acc_cmo),
  .i_acc_cmp  (acc_cmp)
);

`default_nettype wire

/* test/sentinel_profiler_tb.sv */
// Testbench of the sentinel profiler
// Stimulus table, reference model, APB tasks, result checks and summary

`default_nettype none

module sentinel_profiler_tb
  import sentinel_pkg::*;
  import profiler_regs_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int PREADY_TIMEOUT = 16;
  localparam int RAND_GAP       = -1;  // Gap drawn at random

  // addi x0, x0, imm for each sentinel
  localparam logic [31:0] W_TOT_S = 32'h5AA0_0013;
  localparam logic [31:0] W_TOT_E = 32'h5FF0_0013;
  localparam logic [31:0] W_CMI_S = 32'h50B0_0013;
  localparam logic [31:0] W_CMI_E = 32'h50C0_0013;
  localparam logic [31:0] W_CMO_S = 32'h51B0_0013;
  localparam logic [31:0] W_CMO_E = 32'h51C0_0013;
  localparam logic [31:0] W_CMP_S = 32'h52B0_0013;
  localparam logic [31:0] W_CMP_E = 32'h52C0_0013;

  // Immediates by category, TOTAL first
  localparam logic [11:0] START_IMM [N_CAT] =
    '{IMM_TOTAL_START, IMM_CMI_START, IMM_CMO_START, IMM_CMP_START};
  localparam logic [11:0] END_IMM [N_CAT] =
    '{IMM_TOTAL_END, IMM_CMI_END, IMM_CMO_END, IMM_CMP_END};

  typedef struct {
    int          tile;
    logic        valid;
    logic [31:0] word;
    int          gap;    // Idle cycles before the word
  } entry_t;

  logic                   clk;
  logic                   arst_n;
  logic [N_TILES-1:0]     wb_valid;
  sentinel_instr_u        wb_instr [N_TILES];
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [APB_ADDR_W-1:0]  paddr;
  logic [APB_DATA_W-1:0]  pwdata;
  logic [APB_DATA_W-1:0]  prdata;
  logic                   pready;
  logic                   pslverr;

  entry_t   stim [$];
  integer   seed;
  int       now_cyc;
  int       n_tests;
  int       n_checks;
  int       n_errors;

  // Reference model
  acc_t     exp_total [N_TILES];
  acc_t     exp_acc [N_TILES][N_CAT];     // CMI, CMO, CMP used
  err_cnt_t exp_err [N_TILES];
  logic     slot_open [N_TILES][N_CAT];
  int       slot_stamp [N_TILES][N_CAT];

  sentinel_profiler DUT (
    .clk        (clk),
    .i_arst_n   (arst_n),
    .i_wb_valid (wb_valid),
    .i_wb_instr (wb_instr),
    .i_psel     (psel),
    .i_penable  (penable),
    .i_pwrite   (pwrite),
    .i_paddr    (paddr),
    .i_pwdata   (pwdata),
    .o_prdata   (prdata),
    .o_pready   (pready),
    .o_pslverr  (pslverr)
  );

  always #4 clk = ~clk;

  function automatic acc_t sat_sum(acc_t a, acc_t b);
    return (b > ~a) ? '1 : a + b;  // ~a is the headroom left in a
  endfunction

  function automatic int rand_gap();
    return int'($unsigned($random(seed)) % 32'd5) + 1;
  endfunction

  function automatic logic [APB_ADDR_W-1:0] tile_addr(int tile, logic [TILE_OFS_W-1:0] ofs);
    return APB_ADDR_W'(tile * int'(TILE_STRIDE)) + APB_ADDR_W'(ofs);
  endfunction

  task automatic model_reset();
    exp_total  = '{default: '0};
    exp_acc    = '{default: '0};
    exp_err    = '{default: '0};
    slot_open  = '{default: '0};
    slot_stamp = '{default: 0};
  endtask

  // Apply one write-back word presented in cycle cyc
  task automatic model_word(input int tile, input logic valid, input logic [31:0] word,
                            input int cyc);
    logic [11:0] imm;
    acc_t        lat;
    imm = word[31:20];
    if (!valid || word[19:0] != {13'd0, OPC_OP_IMM}) begin
      return;  // rs1, funct3 and rd must all be zero
    end
    for (int c = 0; c < N_CAT; c++) begin
      if (imm == START_IMM[c]) begin
        slot_open[tile][c]  = 1'b1;
        slot_stamp[tile][c] = cyc;
      end else if (imm == END_IMM[c] && !slot_open[tile][c]) begin
        if (exp_err[tile] != '1) begin
          exp_err[tile] = exp_err[tile] + 1'b1;
        end
      end else if (imm == END_IMM[c]) begin
        lat = acc_t'(cyc - slot_stamp[tile][c] - 1);  // One cycle of sentinel overhead
        slot_open[tile][c] = 1'b0;
        if (c == 0) begin
          exp_total[tile] = lat;
        end else begin
          exp_acc[tile][c] = sat_sum(exp_acc[tile][c], lat);
        end
      end
    end
  endtask

  task automatic add_entry(input int tile, input logic valid, input logic [31:0] word,
                           input int gap);
    stim.push_back('{tile, valid, word, gap});
  endtask

  task automatic build_table();
    // TOTAL pairs, one per tile, interleaved
    add_entry(0, 1'b1, W_TOT_S, 0);
    add_entry(1, 1'b1, W_TOT_S, 0);
    add_entry(2, 1'b1, W_TOT_S, 1);
    add_entry(3, 1'b1, W_TOT_S, 0);
    add_entry(0, 1'b1, W_TOT_E, 3);
    add_entry(2, 1'b1, W_TOT_E, 2);
    add_entry(1, 1'b1, W_TOT_E, RAND_GAP);
    add_entry(3, 1'b1, W_TOT_E, 5);
    // Two pairs per category on tile 1, fewer on tiles 2 and 3
    add_entry(1, 1'b1, W_CMI_S, 2);
    add_entry(1, 1'b1, W_CMI_E, 4);
    add_entry(1, 1'b1, W_CMI_S, 0);
    add_entry(2, 1'b1, W_CMI_S, 0);
    add_entry(1, 1'b1, W_CMI_E, RAND_GAP);
    add_entry(1, 1'b1, W_CMO_S, 1);
    add_entry(2, 1'b1, W_CMI_E, 6);
    add_entry(1, 1'b1, W_CMO_E, 3);
    add_entry(1, 1'b1, W_CMO_S, 0);
    add_entry(3, 1'b1, W_CMO_S, 0);
    add_entry(1, 1'b1, W_CMO_E, 2);
    add_entry(1, 1'b1, W_CMP_S, 0);
    add_entry(3, 1'b1, W_CMO_E, RAND_GAP);
    add_entry(1, 1'b1, W_CMP_E, 7);
    add_entry(1, 1'b1, W_CMP_S, 1);
    add_entry(2, 1'b1, W_CMP_S, 0);
    add_entry(1, 1'b1, W_CMP_E, 1);
    add_entry(2, 1'b1, W_CMP_E, 9);
    // Finishes with no open start
    add_entry(0, 1'b1, W_CMI_E, 2);
    add_entry(3, 1'b1, W_CMP_E, 0);
    add_entry(0, 1'b1, W_CMI_E, 0);
    // Look-alike words while a CMI slot is open on tile 0
    add_entry(0, 1'b1, W_CMI_S, 1);
    add_entry(0, 1'b1, 32'h50C0_0093, 0);  // rd = x1
    add_entry(0, 1'b1, 32'h50C0_8013, 0);  // rs1 = x1
    add_entry(0, 1'b1, 32'h50C0_1013, 0);  // funct3 = 1
    add_entry(0, 1'b1, 32'h50C0_0033, 0);  // OP opcode, not OP-IMM
    add_entry(0, 1'b1, 32'h1230_0013, 0);  // Immediate outside the table
    add_entry(0, 1'b0, W_CMI_E, 0);        // Valid low
    add_entry(0, 1'b1, W_CMI_E, 3);
  endtask

  task automatic check_acc(input string name, input acc_t got, input acc_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_err(input string name, input err_cnt_t got, input err_cnt_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // One APB transfer, setup then access until o_pready
  task automatic apb_access(input logic write, input logic [APB_ADDR_W-1:0] addr,
                            input logic [APB_DATA_W-1:0] wdata,
                            output logic [APB_DATA_W-1:0] rdata, output logic slverr);
    int waited;
    waited = 0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    check_flag("o_pready in setup phase", pready, 1'b0);
    penable <= 1'b1;
    do begin
      @(posedge clk);
      waited++;
    end while (!pready && waited < PREADY_TIMEOUT);
    if (!pready) begin
      n_errors++;
      $display("Timeout: o_pready stayed low for %0d cycles at address 0x%02h",
               PREADY_TIMEOUT, addr);
    end
    rdata   = prdata;
    slverr  = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic read_acc(input string name, input logic [APB_ADDR_W-1:0] addr,
                          input acc_t exp);
    logic [APB_DATA_W-1:0] data;
    logic                  err;
    apb_access(1'b0, addr, '0, data, err);
    check_flag($sformatf("o_pslverr reading %s", name), err, 1'b0);
    check_acc(name, acc_t'(data), exp);
  endtask

  task automatic read_err(input string name, input logic [APB_ADDR_W-1:0] addr,
                          input err_cnt_t exp);
    logic [APB_DATA_W-1:0] data;
    logic                  err;
    apb_access(1'b0, addr, '0, data, err);
    check_flag($sformatf("o_pslverr reading %s", name), err, 1'b0);
    check_err(name, err_cnt_t'(data), exp);
  endtask

  task automatic check_totals();
    for (int t = 0; t < N_TILES; t++) begin
      read_acc($sformatf("last_total[%0d]", t), tile_addr(t, OFS_TOTAL), exp_total[t]);
    end
  endtask

  task automatic check_accums();
    for (int t = 0; t < N_TILES; t++) begin
      read_acc($sformatf("acc_cmi[%0d]", t), tile_addr(t, OFS_CMI), exp_acc[t][1]);
      read_acc($sformatf("acc_cmo[%0d]", t), tile_addr(t, OFS_CMO), exp_acc[t][2]);
      read_acc($sformatf("acc_cmp[%0d]", t), tile_addr(t, OFS_CMP), exp_acc[t][3]);
    end
  endtask

  task automatic check_unmatched();
    for (int t = 0; t < N_TILES; t++) begin
      read_err($sformatf("unmatched[%0d]", t), tile_addr(t, OFS_UNMATCHED), exp_err[t]);
    end
  endtask

  task automatic check_maxima();
    acc_t mx [N_CAT];
    acc_t best_sum;
    mx       = '{default: '0};
    best_sum = '0;
    for (int t = 0; t < N_TILES; t++) begin
      for (int c = 1; c < N_CAT; c++) begin
        mx[c] = (exp_acc[t][c] > mx[c]) ? exp_acc[t][c] : mx[c];
      end
      if (sat_sum(sat_sum(exp_acc[t][1], exp_acc[t][2]), exp_acc[t][3]) > best_sum) begin
        best_sum = sat_sum(sat_sum(exp_acc[t][1], exp_acc[t][2]), exp_acc[t][3]);
      end
    end
    read_acc("max_cmi", ADDR_MAX_CMI, mx[1]);
    read_acc("max_cmo", ADDR_MAX_CMO, mx[2]);
    read_acc("max_cmp", ADDR_MAX_CMP, mx[3]);
    read_acc("max_sum", ADDR_MAX_SUM, best_sum);
  endtask

  task automatic end_test(input string name, input int errs_before);
    n_tests++;
    $display("Test %0d, %s: %s", n_tests, name, (n_errors == errs_before) ? "ok" : "errors");
  endtask

  initial begin
    int                    errs;
    int                    gap;
    logic [N_TILES-1:0]    vmask;
    logic [APB_DATA_W-1:0] data;
    logic                  err;
    clk      = 1'b0;
    arst_n   = 1'b0;
    wb_valid = '0;
    wb_instr = '{default: '0};
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    seed     = 32'h1db4_eb27;
    n_tests  = 0;
    n_checks = 0;
    n_errors = 0;
    model_reset();
    build_table();
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;

    errs = n_errors;
    check_totals();
    check_accums();
    check_unmatched();
    check_maxima();
    end_test("all registers zero after reset", errs);

    // Apply the stimulus table, one word per entry
    now_cyc = 0;
    foreach (stim[i]) begin
      gap = (stim[i].gap == RAND_GAP) ? rand_gap() : stim[i].gap;
      repeat (gap) begin
        @(posedge clk);
        wb_valid <= '0;
        now_cyc++;
      end
      @(posedge clk);
      vmask                = '0;
      vmask[stim[i].tile]  = stim[i].valid;
      wb_valid            <= vmask;
      wb_instr[stim[i].tile].raw <= stim[i].word;
      now_cyc++;
      model_word(stim[i].tile, stim[i].valid, stim[i].word, now_cyc);
    end
    @(posedge clk);
    wb_valid <= '0;
    repeat (6) @(posedge clk);  // Drain all stages

    errs = n_errors;
    check_totals();
    end_test("TOTAL latency per tile", errs);
    errs = n_errors;
    check_accums();
    end_test("CMI, CMO and CMP accumulation", errs);
    errs = n_errors;
    check_unmatched();
    end_test("unmatched finishes and ignored words", errs);
    errs = n_errors;
    check_maxima();
    end_test("cross-tile maxima", errs);

    errs = n_errors;
    apb_access(1'b1, ADDR_CLEAR, 32'h1, data, err);
    check_flag("o_pslverr on clear write", err, 1'b0);
    model_reset();
    check_totals();
    check_accums();
    check_unmatched();
    check_maxima();
    apb_access(1'b0, 8'h14, '0, data, err);
    check_flag("o_pslverr on read of 0x14", err, 1'b1);
    apb_access(1'b0, 8'hA0, '0, data, err);
    check_flag("o_pslverr on read of 0xA0", err, 1'b1);
    apb_access(1'b1, tile_addr(1, OFS_CMI), 32'h5, data, err);
    check_flag("o_pslverr on write of acc_cmi[1]", err, 1'b1);
    end_test("clear and bus errors", errs);

    $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
